//--- project.f
bp_pkg.sv
btb.sv
fetch_pc.sv
branch_resolve.sv
bp_top.sv
tb_clock_gen.sv
bp_tb.sv

//--- run.sh
#!/bin/sh
# build the branch predictor testbench with verilator, run it,
# and judge the run by the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module bp_tb \
  -f project.f \
  -o Vbp_tb

# a failed check ends the simulator with a nonzero status, the log decides
./obj_dir/Vbp_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- bp_tb.sv
// bp_tb: random fetch, stall and resolve traffic for bp_top,
// checked every cycle against a reference predictor model
module bp_tb;

  import bp_pkg::*;

  localparam int NUM_CYCLES = 2000;               // test cycles after reset
  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT_T  = (NUM_CYCLES + 3 + 20) * CLK_PERIOD;

  logic              clk, rst;
  logic              stall, res_valid, res_taken, res_pred_taken;
  logic [ADDR_W-1:0] res_pc, res_target, res_pred_target;
  logic [ADDR_W-1:0] pc, pred_target, redirect_pc;
  logic              fetch_valid, hit, pred_taken, redirect;

  // reference model state
  logic              m_valid  [BTB_ENTRIES];
  logic [TAG_W-1:0]  m_tag    [BTB_ENTRIES];
  logic [ADDR_W-1:0] m_target [BTB_ENTRIES];
  ctr_t              m_ctr    [BTB_ENTRIES];
  logic [ADDR_W-1:0] m_pc, m_upd_pc, m_upd_target, m_redirect_pc;
  logic              m_upd_valid, m_upd_taken, m_redirect;
  logic              last_pred_taken  [8];        // prediction seen at last fetch
  logic [ADDR_W-1:0] last_pred_target [8];
  logic [31:0]       lfsr_state;
  int                hit_count, redirect_count, evict_count;

  tb_clock_gen clock_gen (.clk(clk), .rst(rst));

  bp_top UUT (
    .clk(clk), .rst(rst), .stall(stall),
    .res_valid(res_valid), .res_pc(res_pc), .res_taken(res_taken),
    .res_target(res_target), .res_pred_taken(res_pred_taken),
    .res_pred_target(res_pred_target),
    .pc(pc), .fetch_valid(fetch_valid), .hit(hit), .pred_taken(pred_taken),
    .pred_target(pred_target), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);         // one step per bit
      v = {v[6:0], lfsr_state[0]};
    end
  endtask

  // branch pool, 0x1010 and 0x2010 share index 4
  function automatic logic [ADDR_W-1:0] br_addr(input logic [2:0] k);
    case (k)
      3'd0: return 32'h0000_1004;
      3'd1: return 32'h0000_1010;
      3'd2: return 32'h0000_1024;
      3'd3: return 32'h0000_1038;
      3'd4: return 32'h0000_1048;
      3'd5: return 32'h0000_105c;
      3'd6: return 32'h0000_1070;
      default: return 32'h0000_2010;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] tgt_addr(input logic [2:0] k);
    case (k)
      3'd0: return 32'h0000_1000;
      3'd1: return 32'h0000_1020;
      3'd2: return 32'h0000_1040;
      3'd3: return 32'h0000_1060;
      3'd4: return 32'h0000_2000;
      3'd5: return 32'h0000_1014;
      3'd6: return 32'h0000_1030;
      default: return 32'h0000_1050;
    endcase
  endfunction

  function automatic ctr_t step_up(input ctr_t c);
    return (c == ctr_strong_t) ? ctr_strong_t : ctr_t'(c + 2'd1);
  endfunction

  function automatic ctr_t step_down(input ctr_t c);
    return (c == ctr_strong_nt) ? ctr_strong_nt : ctr_t'(c - 2'd1);
  endfunction

  function automatic logic model_hit(input logic [ADDR_W-1:0] a);
    return m_valid[a[7:2]] && (m_tag[a[7:2]] == a[31:8]);
  endfunction

  function automatic logic model_pred_taken(input logic [ADDR_W-1:0] a);
    return model_hit(a) && m_ctr[a[7:2]][1];      // msb of counter gives direction
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // model counter against the direction the dut reports
  task automatic check_ctr(input string name, input ctr_t exp_ctr, input logic act);
    if (act !== exp_ctr[1]) begin
      $display("FAIL t=%0t %s expected %b (counter %s) actual %b", $time, name,
               exp_ctr[1], exp_ctr.name(), act);
      abort_run();
    end
  endtask

  // compares all outputs in the middle of the cycle
  task automatic check_outputs();
    logic [IDX_W-1:0] i;
    logic             mh;
    i  = m_pc[7:2];
    mh = model_hit(m_pc);
    check_addr("pc", m_pc, pc);
    check_flag("fetch_valid", !stall || m_redirect, fetch_valid);
    check_flag("hit", mh, hit);
    check_flag("redirect", m_redirect, redirect);
    if (m_redirect) begin
      check_addr("redirect_pc", m_redirect_pc, redirect_pc);
      redirect_count++;
    end
    if (mh) begin
      check_ctr("pred_taken", m_ctr[i], pred_taken);
      check_addr("pred_target", m_target[i], pred_target);
      hit_count++;
    end else begin
      check_flag("pred_taken", 1'b0, pred_taken); // miss never predicts taken
    end
  endtask

  // remember what fetch predicted for any pool branch it fetches
  task automatic note_fetch();
    if (!stall || m_redirect) begin
      for (int k = 0; k < 8; k++) begin
        if (m_pc == br_addr(3'(k))) begin
          last_pred_taken[3'(k)]  = model_pred_taken(m_pc);
          last_pred_target[3'(k)] = m_target[m_pc[7:2]];
        end
      end
    end
  endtask

  // one clock edge of the reference predictor, inputs are pre-edge values
  task automatic advance_model();
    logic [ADDR_W-1:0] nxt_pc;
    logic [IDX_W-1:0]  ui;
    logic              uhit;
    logic              wrong;
    if (m_redirect) nxt_pc = m_redirect_pc;
    else if (stall) nxt_pc = m_pc;
    else if (model_pred_taken(m_pc)) nxt_pc = m_target[m_pc[7:2]];
    else nxt_pc = m_pc + 32'd4;
    if (m_upd_valid) begin                        // table sees last cycle's resolve
      ui   = m_upd_pc[7:2];
      uhit = model_hit(m_upd_pc);
      if (uhit && m_upd_taken) begin
        m_ctr[ui]    = step_up(m_ctr[ui]);
        m_target[ui] = m_upd_target;
      end else if (uhit) begin
        m_ctr[ui] = step_down(m_ctr[ui]);
      end else if (m_upd_taken) begin
        if (m_valid[ui]) evict_count++;           // alias thrown out
        m_valid[ui]  = 1'b1;
        m_tag[ui]    = m_upd_pc[31:8];
        m_target[ui] = m_upd_target;
        m_ctr[ui]    = ctr_weak_t;
      end
    end
    wrong = (res_taken != res_pred_taken) ||
            (res_taken && res_pred_taken && (res_target != res_pred_target));
    m_upd_valid = res_valid;
    m_redirect  = res_valid && wrong;
    if (res_valid) begin
      m_upd_pc      = res_pc;
      m_upd_taken   = res_taken;
      m_upd_target  = res_target;
      m_redirect_pc = res_taken ? res_target : res_pc + 32'd4;
    end
    m_pc = nxt_pc;
  endtask

  // new inputs for the coming cycle
  task automatic drive_stimulus();
    logic [7:0] b;
    logic [2:0] k;
    logic [2:0] t;
    logic       dir;
    take_bits(2, b);
    stall <= (b[1:0] == 2'b11);                   // about one cycle in four
    take_bits(1, b);
    if (b[0]) begin
      take_bits(3, b);
      k = b[2:0];
      take_bits(2, b);
      dir = (b[1:0] != 2'b00);                    // mostly taken
      take_bits(2, b);
      if (b[1:0] == 2'b11) begin
        take_bits(3, b);
        t = b[2:0];                               // occasional moved target
      end else begin
        t = k;
      end
      res_valid       <= 1'b1;
      res_pc          <= br_addr(k);
      res_taken       <= dir;
      res_target      <= tgt_addr(t);
      res_pred_taken  <= last_pred_taken[k];
      res_pred_target <= last_pred_target[k];
    end else begin
      res_valid <= 1'b0;
    end
  endtask

  initial begin
    stall           <= 1'b0;
    res_valid       <= 1'b0;
    res_pc          <= '0;
    res_taken       <= 1'b0;
    res_target      <= '0;
    res_pred_taken  <= 1'b0;
    res_pred_target <= '0;
    lfsr_state = 32'h350e_991d;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_valid[6'(i)]  = 1'b0;
      m_target[6'(i)] = '0;
      m_ctr[6'(i)]    = ctr_strong_nt;
    end
    for (int k = 0; k < 8; k++) begin
      last_pred_taken[3'(k)]  = 1'b0;
      last_pred_target[3'(k)] = '0;
    end
    m_pc        = RESET_PC;
    m_upd_valid = 1'b0;
    m_redirect  = 1'b0;
    hit_count      = 0;
    redirect_count = 0;
    evict_count    = 0;
    @(negedge rst);
    @(negedge clk);
    // state right after reset
    check_addr("pc", RESET_PC, pc);
    check_flag("fetch_valid", 1'b1, fetch_valid);
    check_flag("hit", 1'b0, hit);
    check_flag("redirect", 1'b0, redirect);
    check_flag("pred_taken", 1'b0, pred_taken);
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      check_outputs();
      @(posedge clk);
      note_fetch();
      advance_model();
      drive_stimulus();
      @(negedge clk);
    end
    if (hit_count == 0 || redirect_count == 0 || evict_count == 0) begin
      $display("random run never produced a hit, a redirect and an alias eviction");
      abort_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT_T);
    $display("watchdog expired before the test loop finished");
    abort_run();
  end

endmodule

//--- tb_clock_gen.sv
// tb_clock_gen: free-running testbench clock of period 100
// and a synchronous reset held high for the first 3 rising edges
module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                       // half of the 100 unit period
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;                                  // released on the third edge
  end

endmodule

//--- bp_top.sv
// bp_top: fetch pc, branch target buffer and resolve stage
// wired together as the fetch-side predictor
module bp_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,           // fetch back-pressure
  input  logic                      res_valid,       // from execute
  input  logic [bp_pkg::ADDR_W-1:0] res_pc,
  input  logic                      res_taken,
  input  logic [bp_pkg::ADDR_W-1:0] res_target,
  input  logic                      res_pred_taken,  // prediction carried down the pipe
  input  logic [bp_pkg::ADDR_W-1:0] res_pred_target,
  output logic [bp_pkg::ADDR_W-1:0] pc,              // fetch address to imem
  output logic                      fetch_valid,
  output logic                      hit,             // btb lookup result
  output logic                      pred_taken,
  output logic [bp_pkg::ADDR_W-1:0] pred_target,
  output logic                      redirect,        // mispredict flush pulse
  output logic [bp_pkg::ADDR_W-1:0] redirect_pc
);

  import bp_pkg::*;

  // resolve to btb update path
  logic              upd_valid;
  logic [ADDR_W-1:0] upd_pc;
  logic              upd_taken;
  logic [ADDR_W-1:0] upd_target;

  fetch_pc u_fetch_pc (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .pc          (pc),
    .fetch_valid (fetch_valid)
  );

  btb u_btb (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),                            // looked up in the fetch cycle
    .upd_valid   (upd_valid),
    .upd_pc      (upd_pc),
    .upd_taken   (upd_taken),
    .upd_target  (upd_target),
    .hit         (hit),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  branch_resolve u_branch_resolve (
    .clk             (clk),
    .rst             (rst),
    .res_valid       (res_valid),
    .res_pc          (res_pc),
    .res_taken       (res_taken),
    .res_target      (res_target),
    .res_pred_taken  (res_pred_taken),
    .res_pred_target (res_pred_target),
    .upd_valid       (upd_valid),
    .upd_pc          (upd_pc),
    .upd_taken       (upd_taken),
    .upd_target      (upd_target),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc)
  );

endmodule

//--- branch_resolve.sv
// branch_resolve: turns resolved branches into btb updates
// and a fetch redirect when the prediction was wrong
module branch_resolve (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      res_valid,       // resolved branch strobe
  input  logic [bp_pkg::ADDR_W-1:0] res_pc,          // branch address
  input  logic                      res_taken,       // actual direction
  input  logic [bp_pkg::ADDR_W-1:0] res_target,      // actual target
  input  logic                      res_pred_taken,  // direction fetch predicted
  input  logic [bp_pkg::ADDR_W-1:0] res_pred_target, // target fetch predicted
  output logic                      upd_valid,       // btb write strobe
  output logic [bp_pkg::ADDR_W-1:0] upd_pc,
  output logic                      upd_taken,
  output logic [bp_pkg::ADDR_W-1:0] upd_target,
  output logic                      redirect,        // one-cycle correction pulse
  output logic [bp_pkg::ADDR_W-1:0] redirect_pc      // where fetch should be
);

  import bp_pkg::*;

  logic              dir_wrong;                   // direction mismatch
  logic              tgt_wrong;                   // both taken, targets differ
  logic              mispredict;                  // either of the above
  logic [ADDR_W-1:0] correct_pc;                  // architecturally next pc

  assign dir_wrong  = res_taken != res_pred_taken;
  assign tgt_wrong  = res_taken && res_pred_taken && (res_target != res_pred_target);
  assign mispredict = dir_wrong || tgt_wrong;

  // taken goes to the target, otherwise fall through
  assign correct_pc = res_taken ? res_target : res_pc + ADDR_W'(4);

  // control strobes, one per resolve, back to back allowed
  always_ff @(posedge clk) begin
    if (rst) begin
      upd_valid <= 1'b0;
      redirect  <= 1'b0;
    end else begin
      upd_valid <= res_valid;                     // every branch trains the table
      redirect  <= res_valid && mispredict;       // only wrong guesses steer fetch
    end
  end

  // payload, captured with the strobe
  always_ff @(posedge clk) begin
    if (res_valid) begin
      upd_pc      <= res_pc;
      upd_taken   <= res_taken;
      upd_target  <= res_target;
      redirect_pc <= correct_pc;
    end
  end

  // a redirect always rides along with its table update
  a_redirect_has_update : assert property (@(posedge clk) disable iff (rst)
    redirect |-> upd_valid);

endmodule

//--- fetch_pc.sv
// fetch_pc: program counter and next fetch address selection
// priority is redirect, stall, predicted target, then sequential
module fetch_pc (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,        // hold the current fetch
  input  logic                      redirect,     // mispredict correction pulse
  input  logic [bp_pkg::ADDR_W-1:0] redirect_pc,  // corrected fetch address
  input  logic                      pred_taken,   // btb says branch taken
  input  logic [bp_pkg::ADDR_W-1:0] pred_target,  // btb target for this pc
  output logic [bp_pkg::ADDR_W-1:0] pc,           // current fetch address
  output logic                      fetch_valid   // fetch issued this cycle
);

  import bp_pkg::*;

  logic [ADDR_W-1:0] next_pc;                     // address for the next edge
  logic [ADDR_W-1:0] seq_pc;                      // fall-through address

  assign seq_pc = pc + ADDR_W'(4);

  // next address select
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;                      // redirect beats stall
    end else if (stall) begin
      next_pc = pc;                               // hold
    end else if (pred_taken) begin
      next_pc = pred_target;                      // follow the btb
    end else begin
      next_pc = seq_pc;
    end
  end

  // a stalled cycle issues nothing unless a redirect overrides it
  assign fetch_valid = !stall || redirect;

  // pc register
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // fetch addresses are always whole instructions
  a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00);

endmodule

//--- btb.sv
// btb: 64-entry direct-mapped branch target buffer
// same-cycle lookup on the fetch pc, registered update from resolve
module btb (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [bp_pkg::ADDR_W-1:0] pc,           // current fetch address
  input  logic                      upd_valid,    // update strobe
  input  logic [bp_pkg::ADDR_W-1:0] upd_pc,       // branch address to train
  input  logic                      upd_taken,    // resolved direction
  input  logic [bp_pkg::ADDR_W-1:0] upd_target,   // resolved target
  output logic                      hit,          // valid entry with matching tag
  output logic                      pred_taken,   // hit and counter says taken
  output logic [bp_pkg::ADDR_W-1:0] pred_target   // stored target of the entry
);

  import bp_pkg::*;

  // table storage, only valid bits see reset
  logic              valid_q  [BTB_ENTRIES];
  logic [TAG_W-1:0]  tag_q    [BTB_ENTRIES];
  logic [ADDR_W-1:0] target_q [BTB_ENTRIES];
  ctr_t              ctr_q    [BTB_ENTRIES];

  logic [IDX_W-1:0]  look_idx;                    // lookup index
  logic [TAG_W-1:0]  look_tag;                    // lookup tag
  logic [IDX_W-1:0]  upd_idx;                     // update index
  logic [TAG_W-1:0]  upd_tag;                     // update tag
  logic              upd_hit;                     // update address already in table
  ctr_t              upd_ctr;                     // current counter of updated entry

  // step toward strongly taken, saturate at the top
  function automatic ctr_t ctr_up(input ctr_t c);
    ctr_t n;
    case (c)
      ctr_strong_nt: n = ctr_weak_nt;
      ctr_weak_nt:   n = ctr_weak_t;
      ctr_weak_t:    n = ctr_strong_t;
      default:       n = ctr_strong_t;
    endcase
    return n;
  endfunction

  // step toward strongly not taken, saturate at the bottom
  function automatic ctr_t ctr_down(input ctr_t c);
    ctr_t n;
    case (c)
      ctr_strong_t:  n = ctr_weak_t;
      ctr_weak_t:    n = ctr_weak_nt;
      ctr_weak_nt:   n = ctr_strong_nt;
      default:       n = ctr_strong_nt;
    endcase
    return n;
  endfunction

  // lookup path, purely combinational
  assign look_idx    = idx_of(pc);
  assign look_tag    = tag_of(pc);
  assign hit         = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
  assign pred_taken  = hit && ctr_taken(ctr_q[look_idx]); // miss predicts not taken
  assign pred_target = target_q[look_idx];        // only meaningful on a hit

  // update side probes the same arrays with the resolved pc
  assign upd_idx = idx_of(upd_pc);
  assign upd_tag = tag_of(upd_pc);
  assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);
  assign upd_ctr = ctr_q[upd_idx];

  // valid bits: cleared on reset, set by a taken allocation
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;                       // empty table after reset
      end
    end else if (upd_valid && upd_taken) begin
      valid_q[upd_idx] <= 1'b1;                   // already set on a hit
    end
  end

  // payload arrays: tag, target and counter
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      if (upd_hit) begin
        if (upd_taken) begin
          ctr_q[upd_idx]    <= ctr_up(upd_ctr);   // strengthen taken
          target_q[upd_idx] <= upd_target;        // target may have moved
        end else begin
          ctr_q[upd_idx]    <= ctr_down(upd_ctr); // lean toward not taken
        end
      end else if (upd_taken) begin
        // allocate on a taken miss, evicts any aliasing branch
        tag_q[upd_idx]    <= upd_tag;
        target_q[upd_idx] <= upd_target;
        ctr_q[upd_idx]    <= ctr_weak_t;
      end
      // miss and not taken leaves the table alone
    end
  end

  // a taken prediction can only come from a real entry
  a_pred_needs_hit : assert property (@(posedge clk) disable iff (rst)
    pred_taken |-> hit);

endmodule

//--- bp_pkg.sv
// bp_pkg: shared geometry, reset address and counter type for the
// fetch-side branch predictor
package bp_pkg;

  localparam int ADDR_W      = 32;               // instruction address width
  localparam int BTB_ENTRIES = 64;               // direct-mapped table depth
  localparam int IDX_W       = 6;                // index from pc[7:2]
  localparam int TAG_W       = 24;               // tag from pc[31:8]
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000; // first fetch after reset

  // 2-bit saturating direction counter, msb set means predict taken
  typedef enum logic [1:0] {
    ctr_strong_nt = 2'b00,
    ctr_weak_nt   = 2'b01,
    ctr_weak_t    = 2'b10,
    ctr_strong_t  = 2'b11
  } ctr_t;

  // table index, skips the two byte-offset bits
  function automatic logic [IDX_W-1:0] idx_of(input logic [ADDR_W-1:0] addr);
    return addr[IDX_W+1:2];
  endfunction

  // tag is everything above the index
  function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:IDX_W+2];
  endfunction

  // direction implied by a counter value
  function automatic logic ctr_taken(input ctr_t c);
    return c[1];
  endfunction

endpackage
